// File: verilog/ow_pkg.sv
// ow_pkg: shared types, encodings and 1-wire slot timings for the DS2505 master
`default_nettype none

package ow_pkg;

    ////////////////////////////////////////////////////////////
    // data types
    ////////////////////////////////////////////////////////////
    typedef logic [7:0]  byte_t;        // one byte on the 1-wire bus
    typedef logic [31:0] quad_t;        // register data, buffer word
    typedef logic [15:0] reg_addr_t;    // host register address
    typedef logic [10:0] mem_addr_t;    // DS2505 byte address (0-2047)
    typedef logic [1:0]  reset_code_t;  // result of the last 1-wire reset

    // bit engine operations
    typedef enum logic [1:0] {
        OP_RESET,
        OP_WRITE_BYTE,
        OP_READ_BYTE
    } ow_op_t;

    // sequencer states, shown in status bits 8:4
    typedef enum logic [4:0] {
        SEQ_IDLE,
        SEQ_RESET,
        SEQ_SEND_CMD,
        SEQ_READ_SLOT,
        SEQ_STORE
    } seq_state_t;

    // control codes in write data bits 1:0
    typedef enum logic [1:0] {
        CTRL_DISABLE,   // release the line
        CTRL_ENABLE,    // take the line
        CTRL_START,     // reset, command program, first buffer
        CTRL_CONT       // next buffer, no reset
    } ctrl_cmd_t;

    localparam reset_code_t RST_NONE        = 2'd0;  // not attempted
    localparam reset_code_t RST_OK          = 2'd1;
    localparam reset_code_t RST_NO_RISE     = 2'd2;  // pull-up missing?
    localparam reset_code_t RST_NO_PRESENCE = 2'd3;

    localparam reg_addr_t DS_STAT_ADDR = 16'h000B;   // control / status quadlet
    localparam byte_t CMD_SKIP_ROM = 8'hCC;
    localparam byte_t CMD_READ_MEM = 8'hF0;

    ////////////////////////////////////////////////////////////
    // slot timings, microseconds
    ////////////////////////////////////////////////////////////
    localparam int unsigned T_RST_LOW   = 480;
    localparam int unsigned T_RISE_MAX  = 5;
    localparam int unsigned T_ACK_WAIT  = 30;
    localparam int unsigned T_ACK_MAX   = 300;
    localparam int unsigned T_RST_REC   = 500;
    localparam int unsigned T_W0_LOW    = 80;
    localparam int unsigned T_W1_LOW    = 8;
    localparam int unsigned T_SLOT      = 90;
    localparam int unsigned T_RD_LOW    = 1;
    localparam int unsigned T_RD_SAMPLE = 15;
    localparam int unsigned T_RD_SLOT   = 121;

endpackage

`default_nettype wire

// File: verilog/ow_byte_if.sv
// ow_byte_if: byte-level operation handshake between the sequencer and the bit engine
`default_nettype none

interface ow_byte_if;
    import ow_pkg::*;

    logic        start;      // one-cycle strobe, engine must be idle
    ow_op_t      op;         // sampled with start
    byte_t       wr_byte;    // sampled with start
    logic        done;       // one-cycle strobe at end of operation
    byte_t       rd_byte;    // valid from done to next start
    reset_code_t rst_code;   // valid from done to next start
    byte_t       rise_time;  // microseconds, 0xFF if not measured

    modport seq (
        output start, op, wr_byte,
        input  done, rd_byte, rst_code, rise_time
    );

    modport eng (
        input  start, op, wr_byte,
        output done, rd_byte, rst_code, rise_time
    );

endinterface

`default_nettype wire

// File: verilog/ow_bit_engine.sv
// ow_bit_engine: times reset/presence, write and read slots on the 1-wire line
`default_nettype none

module ow_bit_engine #(
    parameter int clks_per_us = 49        // clocks per microsecond
) (
    input  wire  clk,
    input  wire  rst_n,
    input  wire  ds_data_in,              // line level
    output logic ds_data_out,             // 0 with ds_dir=1 pulls the line low
    output logic ds_dir,                  // 1 = master drives
    ow_byte_if.eng bus
);
    import ow_pkg::*;

    localparam int PRE_W = $clog2(clks_per_us + 1);
    localparam int US_W  = $clog2(T_RST_REC + 1);   // longest interval counted

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_RST_LOW,
        ST_RST_RISE,
        ST_ACK_WAIT,
        ST_ACK_CHECK,
        ST_RST_REC,
        ST_WRITE,
        ST_READ
    } eng_state_t;

    eng_state_t       state;
    logic [PRE_W-1:0] pre;         // microsecond prescaler
    logic [US_W-1:0]  us_cnt;      // microseconds into current interval
    logic [2:0]       bit_cnt;     // slot index, LSB first
    byte_t            shift;       // write byte, shifted right per slot
    logic             us_tick;
    logic             drive_low;

    assign us_tick = (pre == PRE_W'(clks_per_us - 1));

    // true on the last clock of microsecond t of the interval
    function automatic logic us_at(input int unsigned t);
        return us_tick && (us_cnt == US_W'(t - 1));
    endfunction

    // line request, registered into ds_dir / ds_data_out
    always_comb begin
        case (state)
            ST_RST_LOW: drive_low = 1'b1;
            ST_WRITE:   drive_low = us_cnt < US_W'(shift[0] ? T_W1_LOW : T_W0_LOW);
            ST_READ:    drive_low = us_cnt < US_W'(T_RD_LOW);
            default:    drive_low = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state         <= ST_IDLE;
            pre           <= '0;
            us_cnt        <= '0;
            bit_cnt       <= '0;
            ds_dir        <= 1'b0;          // released to pull-up
            ds_data_out   <= 1'b1;
            bus.done      <= 1'b0;
            bus.rst_code  <= RST_NONE;
            bus.rise_time <= 8'hFF;
        end else begin
            bus.done    <= 1'b0;
            ds_dir      <= drive_low;
            ds_data_out <= !drive_low;
            if (state != ST_IDLE) begin
                pre <= us_tick ? '0 : pre + 1'b1;
                if (us_tick)
                    us_cnt <= us_cnt + 1'b1;
            end
            case (state)
                ST_IDLE: begin
                    if (bus.start) begin
                        pre     <= PRE_W'(1);   // start cycle is the first clock
                        us_cnt  <= '0;
                        bit_cnt <= '0;
                        shift   <= bus.wr_byte;
                        case (bus.op)
                            OP_RESET: begin
                                state         <= ST_RST_LOW;
                                bus.rst_code  <= RST_NONE;
                                bus.rise_time <= 8'hFF;
                            end
                            OP_WRITE_BYTE: state <= ST_WRITE;
                            default:       state <= ST_READ;
                        endcase
                    end
                end
                ST_RST_LOW: begin
                    if (us_at(T_RST_LOW)) begin
                        state  <= ST_RST_RISE;          // release, watch the rise
                        us_cnt <= '0;
                    end
                end
                ST_RST_RISE: begin
                    if (ds_data_in) begin
                        bus.rise_time <= byte_t'(us_cnt);
                        state         <= ST_ACK_WAIT;
                        us_cnt        <= '0;
                    end else if (us_at(T_RISE_MAX)) begin
                        bus.rst_code <= RST_NO_RISE;
                        bus.done     <= 1'b1;
                        state        <= ST_IDLE;
                    end
                end
                ST_ACK_WAIT: begin
                    if (us_at(T_ACK_WAIT)) begin     // slave waits 15-60 us first
                        state  <= ST_ACK_CHECK;
                        us_cnt <= '0;
                    end
                end
                ST_ACK_CHECK: begin
                    if (!ds_data_in) begin
                        bus.rst_code <= RST_OK;         // presence pulse seen
                        state        <= ST_RST_REC;
                        us_cnt       <= '0;
                    end else if (us_at(T_ACK_MAX)) begin
                        bus.rst_code <= RST_NO_PRESENCE;
                        bus.done     <= 1'b1;
                        state        <= ST_IDLE;
                    end
                end
                ST_RST_REC: begin
                    if (us_at(T_RST_REC)) begin
                        bus.done <= 1'b1;
                        state    <= ST_IDLE;
                    end
                end
                default: begin                          // ST_WRITE, ST_READ
                    if (state == ST_READ && us_at(T_RD_SAMPLE))
                        bus.rd_byte[bit_cnt] <= ds_data_in;
                    if (us_at(state == ST_READ ? T_RD_SLOT : T_SLOT)) begin
                        us_cnt  <= '0;
                        bit_cnt <= bit_cnt + 1'b1;
                        shift   <= shift >> 1;
                        if (bit_cnt == 3'd7) begin      // eighth slot over
                            bus.done <= 1'b1;
                            state    <= ST_IDLE;
                        end
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verilog/ow_sequencer.sv
// ow_sequencer: steps through 1-wire reset, memory read command program and read slots
`default_nettype none

module ow_sequencer #(
    parameter int mem_quadlets = 64       // buffer depth
) (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 cmd_start,   // reset + command + first buffer
    input  wire                 cmd_cont,    // next buffer only
    input  ow_pkg::mem_addr_t   start_addr,
    output logic                busy,
    output ow_pkg::seq_state_t  seq_state,
    output logic                byte_valid,  // strobe to the buffer
    output ow_pkg::byte_t       byte_data,
    output logic [$clog2(4*mem_quadlets)-1:0] byte_index,
    ow_byte_if.seq              bus
);
    import ow_pkg::*;

    localparam int IDX_W = $clog2(4 * mem_quadlets);

    seq_state_t       state;
    logic             pending;     // operation issued, waiting for done
    logic [1:0]       pc;          // command program counter
    logic [IDX_W-1:0] byte_cnt;
    mem_addr_t        addr_q;
    byte_t            prog_byte;
    ow_op_t           next_op;

    assign busy      = (state != SEQ_IDLE);
    assign seq_state = state;

    // command program: skip rom, read memory, address lo/hi
    always_comb begin
        case (pc)
            2'd0:    prog_byte = CMD_SKIP_ROM;
            2'd1:    prog_byte = CMD_READ_MEM;
            2'd2:    prog_byte = addr_q[7:0];
            default: prog_byte = {5'd0, addr_q[10:8]};
        endcase
    end

    always_comb begin
        case (state)
            SEQ_RESET:    next_op = OP_RESET;
            SEQ_SEND_CMD: next_op = OP_WRITE_BYTE;
            default:      next_op = OP_READ_BYTE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= SEQ_IDLE;
            pending    <= 1'b0;
            pc         <= '0;
            byte_cnt   <= '0;
            bus.start  <= 1'b0;
            byte_valid <= 1'b0;
        end else begin
            bus.start  <= 1'b0;
            byte_valid <= 1'b0;
            // issue the operation of the current state once
            if (!pending && state inside {SEQ_RESET, SEQ_SEND_CMD, SEQ_READ_SLOT}) begin
                bus.start   <= 1'b1;
                bus.op      <= next_op;
                bus.wr_byte <= prog_byte;
                pending     <= 1'b1;
            end
            case (state)
                SEQ_IDLE: begin
                    pending <= 1'b0;
                    if (cmd_start) begin
                        addr_q <= start_addr;
                        pc     <= '0;
                        state  <= SEQ_RESET;
                    end else if (cmd_cont) begin
                        byte_cnt <= '0;             // device keeps its address
                        state    <= SEQ_READ_SLOT;
                    end
                end
                SEQ_RESET: begin
                    if (pending && bus.done) begin
                        pending <= 1'b0;
                        state   <= (bus.rst_code == RST_OK) ? SEQ_SEND_CMD : SEQ_IDLE;
                    end
                end
                SEQ_SEND_CMD: begin
                    if (pending && bus.done) begin
                        pending <= 1'b0;
                        pc      <= pc + 1'b1;
                        if (pc == 2'd3) begin       // address high byte sent
                            byte_cnt <= '0;
                            state    <= SEQ_READ_SLOT;
                        end
                    end
                end
                SEQ_READ_SLOT: begin
                    if (pending && bus.done) begin
                        pending <= 1'b0;
                        state   <= SEQ_STORE;
                    end
                end
                default: begin                      // SEQ_STORE
                    byte_valid <= 1'b1;
                    byte_data  <= bus.rd_byte;
                    byte_index <= byte_cnt;
                    byte_cnt   <= byte_cnt + 1'b1;
                    state      <= (byte_cnt == IDX_W'(4 * mem_quadlets - 1)) ?
                                  SEQ_IDLE : SEQ_READ_SLOT;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verilog/ow_mem_buffer.sv
// ow_mem_buffer: packs read bytes into quadlets and serves block reads
`default_nettype none

module ow_mem_buffer #(
    parameter int mem_quadlets = 64
) (
    input  wire                clk,
    input  wire                byte_valid,
    input  ow_pkg::byte_t      byte_data,
    input  wire [$clog2(4*mem_quadlets)-1:0] byte_index,
    input  ow_pkg::reg_addr_t  reg_raddr,
    output ow_pkg::quad_t      reg_rdata
);
    import ow_pkg::*;

    localparam int AW = $clog2(mem_quadlets);

    quad_t mem [mem_quadlets];

    logic [AW-1:0] wr_word;
    logic          first_byte;    // byte 0 of a quadlet starts a fresh word

    assign wr_word    = byte_index[AW+1:2];
    assign first_byte = (byte_index[1:0] == 2'd0);

    // bytes enter at the low end, so byte 0 ends up in 31:24
    always_ff @(posedge clk) begin
        if (byte_valid)
            mem[wr_word] <= {(first_byte ? 24'd0 : mem[wr_word][23:0]), byte_data};
    end

    always_ff @(posedge clk) begin
        reg_rdata <= mem[reg_raddr[AW-1:0]];     // block read port
    end

endmodule

`default_nettype wire

// File: verilog/ow_ctrl_regs.sv
// ow_ctrl_regs: control write decode and status word for the 1-wire master
`default_nettype none

module ow_ctrl_regs (
    input  wire                  clk,
    input  wire                  rst_n,
    input  ow_pkg::reg_addr_t    reg_waddr,
    input  wire                  reg_wen,
    input  ow_pkg::quad_t        reg_wdata,
    input  wire                  dout_cfg_bidir,   // bidirectional transceiver fitted
    input  wire                  busy,
    input  ow_pkg::reset_code_t  rst_code,
    input  ow_pkg::byte_t        rise_time,
    input  ow_pkg::seq_state_t   seq_state,
    output logic                 ds_enable,        // master owns the line
    output logic                 cmd_start,
    output logic                 cmd_cont,
    output ow_pkg::mem_addr_t    start_addr,
    output ow_pkg::quad_t        ds_status
);
    import ow_pkg::*;

    logic wr_ok;

    // writes only when idle and the transceiver is bidirectional
    assign wr_ok = reg_wen && (reg_waddr == DS_STAT_ADDR) && dout_cfg_bidir && !busy;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ds_enable <= 1'b0;
            cmd_start <= 1'b0;
            cmd_cont  <= 1'b0;
        end else begin
            cmd_start <= 1'b0;
            cmd_cont  <= 1'b0;
            if (wr_ok) begin
                case (ctrl_cmd_t'(reg_wdata[1:0]))
                    CTRL_DISABLE: ds_enable <= 1'b0;
                    CTRL_ENABLE:  ds_enable <= 1'b1;
                    CTRL_START: begin
                        ds_enable  <= 1'b1;
                        cmd_start  <= 1'b1;
                        start_addr <= reg_wdata[26:16];   // byte address 0-2047
                    end
                    default: cmd_cont <= ds_enable;       // only if line already ours
                endcase
            end
        end
    end

    // status: rise time, busy, state, bidir, reset code, enable
    assign ds_status = {8'd0, rise_time, 2'd0, busy, 4'd0, seq_state,
                        dout_cfg_bidir, rst_code, ds_enable};

endmodule

`default_nettype wire

// File: verilog/ds2505_master.sv
// ds2505_master: direct 1-wire master reading a DS2505 EPROM through the host register bus
`default_nettype none

module ds2505_master #(
    parameter int clks_per_us  = 49,      // 49.152 MHz clock
    parameter int mem_quadlets = 64       // 256 bytes per buffer
) (
    input  wire                clk,
    input  wire                rst_n,
    input  ow_pkg::reg_addr_t  reg_raddr,
    input  ow_pkg::reg_addr_t  reg_waddr,
    input  ow_pkg::quad_t      reg_wdata,
    input  wire                reg_wen,
    output ow_pkg::quad_t      reg_rdata,       // block read data
    output ow_pkg::quad_t      ds_status,
    input  wire                dout_cfg_bidir,
    input  wire                ds_data_in,
    output logic               ds_data_out,
    output logic               ds_dir,          // 1 = drive, 0 = input
    output logic               ds_enable
);
    import ow_pkg::*;

    ////////////////////////////////////////////////////////////
    // internal wiring
    ////////////////////////////////////////////////////////////
    logic       busy;
    logic       cmd_start;
    logic       cmd_cont;
    mem_addr_t  start_addr;
    seq_state_t seq_state;
    logic       byte_valid;
    byte_t      byte_data;
    logic [$clog2(4*mem_quadlets)-1:0] byte_index;

    ow_byte_if ow_bus ();

    ow_ctrl_regs u_ctrl_regs (
        .clk(clk), .rst_n(rst_n),
        .reg_waddr(reg_waddr), .reg_wen(reg_wen), .reg_wdata(reg_wdata),
        .dout_cfg_bidir(dout_cfg_bidir), .busy(busy),
        .rst_code(ow_bus.rst_code), .rise_time(ow_bus.rise_time),
        .seq_state(seq_state), .ds_enable(ds_enable),
        .cmd_start(cmd_start), .cmd_cont(cmd_cont),
        .start_addr(start_addr), .ds_status(ds_status)
    );

    ow_sequencer #(.mem_quadlets(mem_quadlets)) u_sequencer (
        .clk(clk), .rst_n(rst_n),
        .cmd_start(cmd_start), .cmd_cont(cmd_cont), .start_addr(start_addr),
        .busy(busy), .seq_state(seq_state),
        .byte_valid(byte_valid), .byte_data(byte_data), .byte_index(byte_index),
        .bus(ow_bus.seq)
    );

    ow_bit_engine #(.clks_per_us(clks_per_us)) u_bit_engine (
        .clk(clk), .rst_n(rst_n),
        .ds_data_in(ds_data_in), .ds_data_out(ds_data_out), .ds_dir(ds_dir),
        .bus(ow_bus.eng)
    );

    ow_mem_buffer #(.mem_quadlets(mem_quadlets)) u_mem_buffer (
        .clk(clk),
        .byte_valid(byte_valid), .byte_data(byte_data), .byte_index(byte_index),
        .reg_raddr(reg_raddr), .reg_rdata(reg_rdata)
    );

endmodule

`default_nettype wire

// File: test/ds2505_slave_model.sv
// ds2505_slave_model: behavioral DS2505 answering reset, command bytes and read slots
`default_nettype none

module ds2505_slave_model #(
    parameter int us_time = 400             // time units per microsecond
) (
    input  wire        clk,
    input  wire        line,                // shared 1-wire level
    output logic       drv,                 // 0 pulls the line low
    input  wire        present,             // answer resets with presence
    input  wire        load_en,
    input  wire [10:0] load_addr,
    input  wire [7:0]  load_data,
    output int         cmd_errs             // bad command bytes seen
);
    logic [7:0]  mem [2048];
    logic [10:0] addr;
    logic [10:0] fill_addr;
    logic [7:0]  rx;
    logic        reading;                   // past the address bytes
    int          bit_n;
    int          byte_n;
    time         t0;
    time         dur;

    always @(posedge clk) begin
        if (load_en)
            mem[load_addr] <= load_data;
    end

    // command program byte checker
    task automatic take_byte(input logic [7:0] b);
        case (byte_n)
            0: if (b != 8'hCC) cmd_errs++;  // skip rom
            1: if (b != 8'hF0) cmd_errs++;  // read memory
            2: addr[7:0] = b;
            default: begin
                addr[10:8] = b[2:0];
                reading    = 1'b1;
            end
        endcase
        byte_n++;
    endtask

    initial begin
        for (int a = 0; a < 2048; a++) begin
            fill_addr = 11'(a);
            mem[a] = fill_addr[7:0] ^ {fill_addr[10:8], 5'h0A};  // whole-address pattern
        end
        drv      = 1'b1;
        cmd_errs = 0;
        reading  = 1'b0;
        bit_n    = 0;
        byte_n   = 0;
        addr     = '0;
        rx       = '0;
        forever begin
            @(negedge line);
            t0 = $time;
            if (reading && !mem[addr][bit_n]) begin
                drv = 1'b0;                     // hold low past the master sample
                #(45 * us_time);
                drv = 1'b1;
            end
            if (line !== 1'b1)
                @(posedge line);
            dur = $time - t0;
            if (dur >= 400 * us_time) begin     // reset pulse
                reading = 1'b0;
                bit_n   = 0;
                byte_n  = 0;
                #(20 * us_time);
                if (present) begin
                    drv = 1'b0;                 // presence pulse
                    #(120 * us_time);
                    drv = 1'b1;
                end
            end else if (reading) begin
                bit_n++;
                if (bit_n == 8) begin
                    bit_n = 0;
                    addr  = addr + 1'b1;
                end
            end else begin
                rx = {(dur < 40 * us_time), rx[7:1]};   // short low is a one, LSB first
                bit_n++;
                if (bit_n == 8) begin
                    bit_n = 0;
                    take_byte(rx);
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: test/ds2505_asserts.sv
// ds2505_asserts: line protocol and byte handshake assertions bound into the master
`default_nettype none

module ds2505_asserts (
    input wire clk,
    input wire rst_n,
    input wire ds_dir,
    input wire ds_data_out,
    input wire ds_enable,
    input wire start,          // engine start strobe
    input wire done            // engine done strobe
);
    logic running;             // engine operation in flight

    always @(posedge clk) begin
        if (!rst_n)
            running <= 1'b0;
        else if (start)
            running <= 1'b1;
        else if (done)
            running <= 1'b0;
    end

    a_no_drive_disabled: assert property (@(posedge clk) disable iff (!rst_n)
        (ds_dir && !ds_data_out) |-> ds_enable)
        else $error("master pulls the line low while the interface is disabled");

    a_done_after_start: assert property (@(posedge clk) disable iff (!rst_n)
        done |-> running)
        else $error("done strobe without a preceding start");

    a_start_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
        start |-> !running)
        else $error("start strobe while an operation is running");

endmodule

bind ds2505_master ds2505_asserts u_asserts (
    .clk(clk), .rst_n(rst_n), .ds_dir(ds_dir), .ds_data_out(ds_data_out),
    .ds_enable(ds_enable), .start(ow_bus.start), .done(ow_bus.done)
);

`default_nettype wire

// File: test/tb_ds2505.sv
// tb_ds2505: trace driven testbench for the DS2505 1-wire master
`default_nettype none

module tb_ds2505;
    import ow_pkg::*;

    localparam int CLKS_PER_US  = 4;
    localparam int MEM_QUADLETS = 4;
    localparam int MAX_TESTS    = 32;
    // worst case per test: reset, 4 write bytes, 16 read bytes
    localparam int TEST_CYCLES  = (T_RST_LOW + T_RISE_MAX + T_ACK_WAIT + T_ACK_MAX
        + T_RST_REC + 4 * 8 * T_SLOT + 16 * 8 * T_RD_SLOT) * CLKS_PER_US;

    logic clk = 1'b0;
    logic rst_n;
    reg_addr_t reg_raddr, reg_waddr;
    quad_t reg_wdata, reg_rdata, ds_status;
    logic reg_wen, dout_cfg_bidir, ds_data_out, ds_dir, ds_enable;
    logic present, load_en, sl_drv;
    logic [10:0] load_addr;
    logic [7:0] load_data;
    int slave_errs;
    wire line = !(ds_dir && !ds_data_out) && sl_drv;   // wired-AND with pull-up

    int kind [MAX_TESTS], bidir [MAX_TESTS], pres [MAX_TESTS], code [MAX_TESTS], en [MAX_TESTS];
    logic [31:0] waddr [MAX_TESTS], wdata [MAX_TESTS], maddr [MAX_TESTS];
    quad_t exp_q [MAX_TESTS][4];
    int n_tests = 0, errors = 0, failed = 0, cycles = 0, limit = 0;

    always #50 clk = !clk;

    ds2505_master #(.clks_per_us(CLKS_PER_US), .mem_quadlets(MEM_QUADLETS)) uut (
        .clk(clk), .rst_n(rst_n), .reg_raddr(reg_raddr), .reg_waddr(reg_waddr),
        .reg_wdata(reg_wdata), .reg_wen(reg_wen), .reg_rdata(reg_rdata),
        .ds_status(ds_status), .dout_cfg_bidir(dout_cfg_bidir), .ds_data_in(line),
        .ds_data_out(ds_data_out), .ds_dir(ds_dir), .ds_enable(ds_enable)
    );

    ds2505_slave_model #(.us_time(CLKS_PER_US * 100)) slave (
        .clk(clk), .line(line), .drv(sl_drv), .present(present), .load_en(load_en),
        .load_addr(load_addr), .load_data(load_data), .cmd_errs(slave_errs)
    );

    // watchdog, limit set once the trace is known
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit != 0 && cycles >= limit) begin
            $display("timeout: run did not finish within %0d cycles", limit);
            $display("test failed");
            $finish;
        end
    end

    task automatic check_value(input string what, input logic [31:0] got, exp);
        assert (got === exp) else begin
            $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic read_trace();
        int fd;
        int n;
        string txt;
        fd = $fopen("test/ds2505_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open the trace file");
            errors++;
        end else begin
            while ($fgets(txt, fd) > 0) begin
                if (txt.len() > 1 && txt[0] != "#" && n_tests < MAX_TESTS) begin
                    n = $sscanf(txt, "%d %h %h %d %d %h %d %d %h %h %h %h",
                        kind[n_tests], waddr[n_tests], wdata[n_tests], bidir[n_tests],
                        pres[n_tests], maddr[n_tests], code[n_tests], en[n_tests],
                        exp_q[n_tests][0], exp_q[n_tests][1], exp_q[n_tests][2],
                        exp_q[n_tests][3]);
                    if (n == 12) n_tests++;
                end
            end
            $fclose(fd);
        end
    endtask

    // put the expected bytes into slave memory, first byte from bits 31:24
    task automatic load_slave(input int t);
        for (int j = 0; j < 16; j++) begin
            @(posedge clk);
            load_en   <= 1'b1;
            load_addr <= 11'(maddr[t] + 32'(j));
            load_data <= exp_q[t][j / 4][31 - 8 * (j % 4) -: 8];
        end
        @(posedge clk);
        load_en <= 1'b0;
    endtask

    task automatic write_ctrl(input int t);
        @(posedge clk);
        reg_waddr <= reg_addr_t'(waddr[t]);
        reg_wdata <= wdata[t];
        reg_wen   <= 1'b1;
        @(posedge clk);
        reg_wen <= 1'b0;
    endtask

    task automatic run_test(input int t);
        int errs0;
        errs0 = errors;
        // slave memory keeps its fill pattern when the reset is to fail
        if (kind[t] == 2 && code[t] == 1)
            load_slave(t);
        @(posedge clk);
        present        <= pres[t][0];
        dout_cfg_bidir <= bidir[t][0];
        if (kind[t] > 0)
            write_ctrl(t);
        if (kind[t] == 2) begin
            @(negedge clk);
            while (!ds_status[13]) @(negedge clk);   // busy rises
            while (ds_status[13]) @(negedge clk);    // read finished
        end else begin
            repeat (6) @(posedge clk);
        end
        @(negedge clk);
        if (kind[t] != 2)
            check_value("busy", 32'(ds_status[13]), 32'd0);
        check_value("reset code", 32'(ds_status[2:1]), 32'(code[t]));
        check_value("status bidir", 32'(ds_status[3]), 32'(bidir[t]));
        check_value("status state", 32'(ds_status[8:4]), 32'd0);     // back in idle
        // ideal pull-up rises within the first microsecond, FF when not measured
        check_value("rise time", 32'(ds_status[23:16]),
                    (code[t] == 0 || code[t] == 2) ? 32'hFF : 32'h00);
        check_value("status enable", 32'(ds_status[0]), 32'(en[t]));
        check_value("ds_enable", 32'(ds_enable), 32'(en[t]));
        if (kind[t] == 2) begin
            check_value("slave command errors", 32'(slave_errs), 32'd0);
            for (int i = 0; i < 4; i++) begin
                @(posedge clk);
                reg_raddr <= reg_addr_t'(i);
                @(posedge clk);
                @(negedge clk);
                check_value($sformatf("buffer word %0d", i), reg_rdata, exp_q[t][i]);
            end
        end
        if (errors != errs0) failed++;
        $display("test %0d (kind %0d): %s", t, kind[t], (errors == errs0) ? "ok" : "FAIL");
    endtask

    initial begin
        rst_n          = 1'b0;
        reg_raddr      = '0;
        reg_waddr      = '0;
        reg_wdata      = '0;
        reg_wen        = 1'b0;
        dout_cfg_bidir = 1'b0;
        present        = 1'b1;
        load_en        = 1'b0;
        load_addr      = '0;
        load_data      = '0;
        read_trace();
        limit = n_tests * TEST_CYCLES * 2 + 200;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        for (int t = 0; t < n_tests; t++)
            run_test(t);
        $display("%0d tests, %0d failed, %0d errors", n_tests, failed, errors);
        if (errors == 0 && n_tests > 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
verilog/ow_pkg.sv
verilog/ow_byte_if.sv
verilog/ow_bit_engine.sv
verilog/ow_sequencer.sv
verilog/ow_mem_buffer.sv
verilog/ow_ctrl_regs.sv
verilog/ds2505_master.sv
test/ds2505_slave_model.sv
test/ds2505_asserts.sv
test/tb_ds2505.sv

// File: Makefile
# Verilator build and run for the DS2505 1-wire master testbench

VERILATOR ?= verilator
TOP       ?= tb_ds2505
FLIST     ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= test passed

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: compile
	@out="$$(./$(SIM_BIN))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: test/ds2505_trace.txt
# kind waddr wdata bidir present maddr code en q0 q1 q2 q3   (kind 0 idle, 1 write, 2 read run)
# maddr = slave byte address loaded with q0..q3, code/en = expected status bits 2:1 and 0
0 000B 00000000 1 1 0000 0 0 00000000 00000000 00000000 00000000
1 000C 01230002 1 1 0000 0 0 00000000 00000000 00000000 00000000
1 000B 01230002 0 1 0000 0 0 00000000 00000000 00000000 00000000
1 000B 00000001 1 1 0000 0 1 00000000 00000000 00000000 00000000
1 000B 00000000 1 1 0000 0 0 00000000 00000000 00000000 00000000
2 000B 01230002 1 1 0123 1 1 3C5A1F80 11223344 A5C3E7F0 0F1E2D3C
2 000B 00000003 1 1 0133 1 1 90817263 DEADBEEF 55AA00FF 13579BDF
2 000B 04000002 1 0 0400 3 1 90817263 DEADBEEF 55AA00FF 13579BDF
2 000B 07E00002 1 1 07E0 1 1 01020304 F1E2D3C4 7F806699 C0FFEE00
